// ==== armPkg.sv ====
package armPkg;

   // Data path and register index sizes
   localparam int WordWidth = 32;
   localparam int RegAddrWidth = 4;
   localparam logic [RegAddrWidth-1:0] RegPc = 4'd15;   // Reads as PC+8

   // Instruction class in bits 27:26
   localparam logic [1:0] OpDataProc = 2'b00;
   localparam logic [1:0] OpMemory = 2'b01;
   localparam logic [1:0] OpBranch = 2'b10;

   // Data-processing cmd field, bits 24:21
   localparam logic [3:0] CmdAnd = 4'b0000;
   localparam logic [3:0] CmdSub = 4'b0010;
   localparam logic [3:0] CmdAdd = 4'b0100;
   localparam logic [3:0] CmdOrr = 4'b1100;

   // ALU operation select
   localparam logic [1:0] AluAdd = 2'b00;
   localparam logic [1:0] AluSub = 2'b01;
   localparam logic [1:0] AluAnd = 2'b10;
   localparam logic [1:0] AluOrr = 2'b11;

   // Operand source in execute
   localparam logic [1:0] FwdNone = 2'b00;
   localparam logic [1:0] FwdWriteback = 2'b01;
   localparam logic [1:0] FwdMemory = 2'b10;

   localparam logic [3:0] CondAlways = 4'b1110;

   // Immediate extension select
   localparam logic [1:0] ImmDataProc = 2'b00;
   localparam logic [1:0] ImmMemory = 2'b01;
   localparam logic [1:0] ImmBranch = 2'b10;

   // One instruction word, seen as data processing / memory or as branch
   typedef union packed {
      struct packed {
         logic [3:0] cond;
         logic [1:0] op;
         logic immFlag;
         logic [3:0] cmd;
         logic sBit;             // L bit for LDR/STR
         logic [3:0] rn;
         logic [3:0] rd;
         logic [11:0] operand2;
      } dp;
      struct packed {
         logic [3:0] cond;
         logic [1:0] op;
         logic [1:0] funct;
         logic [23:0] offset;    // Signed word offset
      } br;
   } instrT;

endpackage

// ==== armCondition.sv ====
`timescale 1ns/1ps

module armCondition
   import armPkg::*;
(
   input  logic [3:0] cond,
   input  logic [3:0] flags,
   input  logic [3:0] aluFlags,
   input  logic [1:0] flagWrite,
   output logic       condEx,
   output logic [3:0] flagsNext
);

   logic n, z, c, v;
   logic ge;

   assign {n, z, c, v} = flags;
   assign ge = (n == v);

   always_comb
   begin
      case (cond)
         4'b0000: condEx = z;              // EQ
         4'b0001: condEx = ~z;             // NE
         4'b0010: condEx = c;              // CS
         4'b0011: condEx = ~c;             // CC
         4'b0100: condEx = n;              // MI
         4'b0101: condEx = ~n;             // PL
         4'b0110: condEx = v;              // VS
         4'b0111: condEx = ~v;             // VC
         4'b1000: condEx = c & ~z;         // HI
         4'b1001: condEx = ~c | z;         // LS
         4'b1010: condEx = ge;             // GE
         4'b1011: condEx = ~ge;            // LT
         4'b1100: condEx = ~z & ge;        // GT
         4'b1101: condEx = z | ~ge;        // LE
         CondAlways: condEx = 1'b1;
         default: condEx = 1'b0;           // 1111 never executes
      endcase
   end

   // N/Z and C/V are written separately, logic ops keep C and V
   assign flagsNext[3:2] = (flagWrite[1] & condEx) ? aluFlags[3:2] : flags[3:2];
   assign flagsNext[1:0] = (flagWrite[0] & condEx) ? aluFlags[1:0] : flags[1:0];

endmodule

// ==== armAlu.sv ====
`timescale 1ns/1ps

module armAlu
   import armPkg::*;
(
   input  logic [WordWidth-1:0] a,
   input  logic [WordWidth-1:0] b,
   input  logic [1:0]           aluControl,
   output logic [WordWidth-1:0] result,
   output logic [3:0]           aluFlags
);

   logic subtract;
   logic arith;
   logic [WordWidth-1:0] bInv;
   logic [WordWidth:0] sum;        // Extra bit is the carry out

   assign subtract = (aluControl == AluSub);
   assign arith = (aluControl == AluAdd) | subtract;
   assign bInv = subtract ? ~b : b;
   assign sum = {1'b0, a} + {1'b0, bInv} + {{WordWidth{1'b0}}, subtract};

   always_comb
   begin
      case (aluControl)
         AluAnd: result = a & b;
         AluOrr: result = a | b;
         default: result = sum[WordWidth-1:0];
      endcase
   end

   // NZCV
   assign aluFlags[3] = result[WordWidth-1];
   assign aluFlags[2] = (result == '0);
   assign aluFlags[1] = arith & sum[WordWidth];
   assign aluFlags[0] = arith & ~(a[WordWidth-1] ^ bInv[WordWidth-1])
                        & (a[WordWidth-1] ^ sum[WordWidth-1]);

endmodule

// ==== armRegFile.sv ====
`timescale 1ns/1ps

module armRegFile
   import armPkg::*;
(
   input  logic                    clk,
   input  logic                    we3,
   input  logic [RegAddrWidth-1:0] ra1,
   input  logic [RegAddrWidth-1:0] ra2,
   input  logic [RegAddrWidth-1:0] wa3,
   input  logic [WordWidth-1:0]    wd3,
   input  logic [WordWidth-1:0]    r15,
   output logic [WordWidth-1:0]    rd1,
   output logic [WordWidth-1:0]    rd2
);

   logic [WordWidth-1:0] regs [0:14];   // R0 to R14

   // Write at mid-cycle so decode sees the writeback value
   always_ff @(negedge clk)
   begin
      if (we3)
         regs[wa3] <= wd3;
   end

   assign rd1 = (ra1 == RegPc) ? r15 : regs[ra1];
   assign rd2 = (ra2 == RegPc) ? r15 : regs[ra2];

endmodule

// ==== armHazard.sv ====
`timescale 1ns/1ps

module armHazard
   import armPkg::*;
(
   input  logic [RegAddrWidth-1:0] ra1D,
   input  logic [RegAddrWidth-1:0] ra2D,
   input  logic [RegAddrWidth-1:0] ra1E,
   input  logic [RegAddrWidth-1:0] ra2E,
   input  logic [RegAddrWidth-1:0] wa3E,
   input  logic [RegAddrWidth-1:0] wa3M,
   input  logic [RegAddrWidth-1:0] wa3W,
   input  logic                    regWriteM,
   input  logic                    regWriteW,
   input  logic                    memToRegE,
   input  logic                    branchTakenE,
   output logic [1:0]              forwardAE,
   output logic [1:0]              forwardBE,
   output logic                    stallF,
   output logic                    stallD,
   output logic                    flushD,
   output logic                    flushE
);

   logic match1EM, match1EW, match2EM, match2EW;
   logic match12DE;
   logic ldrStall;

   assign match1EM = (ra1E == wa3M);
   assign match1EW = (ra1E == wa3W);
   assign match2EM = (ra2E == wa3M);
   assign match2EW = (ra2E == wa3W);
   assign match12DE = (ra1D == wa3E) | (ra2D == wa3E);

   // Newer result in memory wins over writeback
   assign forwardAE = (match1EM & regWriteM) ? FwdMemory :
                      (match1EW & regWriteW) ? FwdWriteback : FwdNone;
   assign forwardBE = (match2EM & regWriteM) ? FwdMemory :
                      (match2EW & regWriteW) ? FwdWriteback : FwdNone;

   assign ldrStall = match12DE & memToRegE;   // Load result not ready yet

   assign stallF = ldrStall;
   assign stallD = ldrStall;
   assign flushE = ldrStall | branchTakenE;
   assign flushD = branchTakenE;   // Wrong-path fetch

endmodule

// ==== armControl.sv ====
`timescale 1ns/1ps

module armControl
   import armPkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       flushE,
   input  instrT      instrD,
   input  logic [3:0] aluFlagsE,
   output logic [1:0] regSrcD,
   output logic [1:0] immSrcD,
   output logic       aluSrcE,
   output logic [1:0] aluControlE,
   output logic       branchTakenE,
   output logic       memWrite,
   output logic       memToRegE,
   output logic       memToRegW,
   output logic       regWriteM,
   output logic       regWriteW
);

   logic aluSrcD, memToRegD, regWriteD, memWriteD, branchD;
   logic [1:0] aluControlD, flagWriteD;
   logic regWriteE, memWriteE, branchE, memToRegM;
   logic [1:0] flagWriteE;
   logic [3:0] condE, flagsE, flagsNextE;
   logic condExE;

   always_comb
   begin
      regSrcD = 2'b00;
      immSrcD = ImmDataProc;
      aluSrcD = 1'b0;
      memToRegD = 1'b0;
      regWriteD = 1'b0;
      memWriteD = 1'b0;
      branchD = 1'b0;
      aluControlD = AluAdd;          // Address and target adds
      case (instrD.dp.op)
         OpDataProc:
         begin
            aluSrcD = instrD.dp.immFlag;
            regWriteD = 1'b1;
            case (instrD.dp.cmd)
               CmdSub: aluControlD = AluSub;
               CmdAnd: aluControlD = AluAnd;
               CmdOrr: aluControlD = AluOrr;
               default: aluControlD = AluAdd;
            endcase
         end
         OpMemory:
         begin
            immSrcD = ImmMemory;
            aluSrcD = 1'b1;
            memToRegD = instrD.dp.sBit;   // LDR
            regWriteD = instrD.dp.sBit;
            memWriteD = ~instrD.dp.sBit;
            regSrcD[1] = ~instrD.dp.sBit; // STR reads Rd as data
         end
         OpBranch:
         begin
            regSrcD[0] = 1'b1;            // Base is R15
            immSrcD = ImmBranch;
            aluSrcD = 1'b1;
            branchD = 1'b1;
         end
         default: ;
      endcase
   end

   // Only data processing with S writes flags, C/V only for ADD and SUB
   assign flagWriteD[1] = (instrD.dp.op == OpDataProc) & instrD.dp.sBit;
   assign flagWriteD[0] = flagWriteD[1] & ~aluControlD[1];

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         {regWriteE, memWriteE, memToRegE, branchE, aluSrcE,
          aluControlE, flagWriteE, condE} <= '0;
      else if (flushE)
         {regWriteE, memWriteE, memToRegE, branchE, aluSrcE,
          aluControlE, flagWriteE, condE} <= '0;   // Bubble
      else
         {regWriteE, memWriteE, memToRegE, branchE, aluSrcE,
          aluControlE, flagWriteE, condE} <= {regWriteD, memWriteD, memToRegD,
          branchD, aluSrcD, aluControlD, flagWriteD, instrD.dp.cond};
   end

   armCondition i_armCondition (
      .cond(condE),
      .flags(flagsE),
      .aluFlags(aluFlagsE),
      .flagWrite(flagWriteE),
      .condEx(condExE),
      .flagsNext(flagsNextE)
   );

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         flagsE <= 4'b0;
      else
         flagsE <= flagsNextE;
   end

   assign branchTakenE = branchE & condExE;

   // Memory and writeback controls, already condition gated
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         {memWrite, memToRegM, regWriteM, memToRegW, regWriteW} <= '0;
      else
         {memWrite, memToRegM, regWriteM, memToRegW, regWriteW} <=
            {memWriteE & condExE, memToRegE, regWriteE & condExE, memToRegM, regWriteM};
   end

endmodule

// ==== armDatapath.sv ====
`timescale 1ns/1ps

module armDatapath
   import armPkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic [1:0]              regSrcD,
   input  logic [1:0]              immSrcD,
   input  logic                    aluSrcE,
   input  logic [1:0]              aluControlE,
   input  logic                    branchTakenE,
   input  logic                    memToRegW,
   input  logic                    regWriteW,
   input  logic [1:0]              forwardAE,
   input  logic [1:0]              forwardBE,
   input  logic                    stallF,
   input  logic                    stallD,
   input  logic                    flushD,
   input  logic [WordWidth-1:0]    instr,
   input  logic [WordWidth-1:0]    readData,
   output logic [WordWidth-1:0]    pc,
   output instrT                   instrD,
   output logic [WordWidth-1:0]    aluOut,
   output logic [WordWidth-1:0]    writeData,
   output logic [3:0]              aluFlagsE,
   output logic [RegAddrWidth-1:0] ra1D,
   output logic [RegAddrWidth-1:0] ra2D,
   output logic [RegAddrWidth-1:0] ra1E,
   output logic [RegAddrWidth-1:0] ra2E,
   output logic [RegAddrWidth-1:0] wa3E,
   output logic [RegAddrWidth-1:0] wa3M,
   output logic [RegAddrWidth-1:0] wa3W
);

   logic [WordWidth-1:0] pcPlus4F, pcNext;
   logic [WordWidth-1:0] rd1D, rd2D, extImmD;
   logic [WordWidth-1:0] rd1E, rd2E, extImmE;
   logic [WordWidth-1:0] srcAE, srcBE, writeDataE, aluResultE;
   logic [WordWidth-1:0] aluOutW, readDataW, resultW;

   function automatic logic [WordWidth-1:0] forwardMux(
      input logic [1:0] sel,
      input logic [WordWidth-1:0] regValue,
      input logic [WordWidth-1:0] wbValue,
      input logic [WordWidth-1:0] memValue
   );
      case (sel)
         FwdMemory: forwardMux = memValue;
         FwdWriteback: forwardMux = wbValue;
         default: forwardMux = regValue;
      endcase
   endfunction

   // Fetch
   assign pcPlus4F = pc + 32'd4;
   assign pcNext = branchTakenE ? aluResultE : pcPlus4F;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         pc <= '0;
      else if (~stallF)
         pc <= pcNext;
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         instrD <= '0;
      else if (flushD)
         instrD <= '0;
      else if (~stallD)
         instrD <= instr;
   end

   // Decode
   assign ra1D = regSrcD[0] ? RegPc : instrD.dp.rn;
   assign ra2D = regSrcD[1] ? instrD.dp.rd : instrD.dp.operand2[3:0];

   armRegFile i_armRegFile (
      .clk(clk),
      .we3(regWriteW),
      .ra1(ra1D),
      .ra2(ra2D),
      .wa3(wa3W),
      .wd3(resultW),
      .r15(pcPlus4F),              // Decode PC + 8
      .rd1(rd1D),
      .rd2(rd2D)
   );

   always_comb
   begin
      case (immSrcD)
         ImmDataProc: extImmD = {{(WordWidth-8){1'b0}}, instrD.dp.operand2[7:0]};
         ImmMemory: extImmD = {{(WordWidth-12){1'b0}}, instrD.dp.operand2};
         ImmBranch: extImmD = {{6{instrD.br.offset[23]}}, instrD.br.offset, 2'b00};
         default: extImmD = '0;
      endcase
   end

   // Execute
   always_ff @(posedge clk)
   begin
      rd1E <= rd1D;
      rd2E <= rd2D;
      extImmE <= extImmD;
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         {ra1E, ra2E, wa3E} <= '0;
      else
         {ra1E, ra2E, wa3E} <= {ra1D, ra2D, instrD.dp.rd};
   end

   assign srcAE = forwardMux(forwardAE, rd1E, resultW, aluOut);
   assign writeDataE = forwardMux(forwardBE, rd2E, resultW, aluOut);
   assign srcBE = aluSrcE ? extImmE : writeDataE;

   armAlu i_armAlu (
      .a(srcAE),
      .b(srcBE),
      .aluControl(aluControlE),
      .result(aluResultE),
      .aluFlags(aluFlagsE)
   );

   // Memory
   always_ff @(posedge clk)
   begin
      aluOut <= aluResultE;
      writeData <= writeDataE;
   end

   // Writeback
   always_ff @(posedge clk)
   begin
      aluOutW <= aluOut;
      readDataW <= readData;
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         {wa3M, wa3W} <= '0;
      else
         {wa3M, wa3W} <= {wa3E, wa3M};
   end

   assign resultW = memToRegW ? readDataW : aluOutW;

endmodule

// ==== armCore.sv ====
`timescale 1ns/1ps

module armCore
   import armPkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic [WordWidth-1:0] instr,
   input  logic [WordWidth-1:0] readData,
   output logic [WordWidth-1:0] pc,
   output logic [WordWidth-1:0] aluOut,
   output logic [WordWidth-1:0] writeData,
   output logic                 memWrite
);

   logic [1:0] regSrcD, immSrcD, aluControlE;
   logic aluSrcE, branchTakenE, memToRegE, memToRegW, regWriteM, regWriteW;
   instrT instrD;
   logic [3:0] aluFlagsE;
   logic [RegAddrWidth-1:0] ra1D, ra2D, ra1E, ra2E, wa3E, wa3M, wa3W;
   logic [1:0] forwardAE, forwardBE;
   logic stallF, stallD, flushD, flushE;

   armControl i_armControl (
      .clk(clk),
      .reset(reset),
      .flushE(flushE),
      .instrD(instrD),
      .aluFlagsE(aluFlagsE),
      .regSrcD(regSrcD),
      .immSrcD(immSrcD),
      .aluSrcE(aluSrcE),
      .aluControlE(aluControlE),
      .branchTakenE(branchTakenE),
      .memWrite(memWrite),
      .memToRegE(memToRegE),
      .memToRegW(memToRegW),
      .regWriteM(regWriteM),
      .regWriteW(regWriteW)
   );

   armDatapath i_armDatapath (
      .clk(clk),
      .reset(reset),
      .regSrcD(regSrcD),
      .immSrcD(immSrcD),
      .aluSrcE(aluSrcE),
      .aluControlE(aluControlE),
      .branchTakenE(branchTakenE),
      .memToRegW(memToRegW),
      .regWriteW(regWriteW),
      .forwardAE(forwardAE),
      .forwardBE(forwardBE),
      .stallF(stallF),
      .stallD(stallD),
      .flushD(flushD),
      .instr(instr),
      .readData(readData),
      .pc(pc),
      .instrD(instrD),
      .aluOut(aluOut),
      .writeData(writeData),
      .aluFlagsE(aluFlagsE),
      .ra1D(ra1D),
      .ra2D(ra2D),
      .ra1E(ra1E),
      .ra2E(ra2E),
      .wa3E(wa3E),
      .wa3M(wa3M),
      .wa3W(wa3W)
   );

   armHazard i_armHazard (
      .ra1D(ra1D),
      .ra2D(ra2D),
      .ra1E(ra1E),
      .ra2E(ra2E),
      .wa3E(wa3E),
      .wa3M(wa3M),
      .wa3W(wa3W),
      .regWriteM(regWriteM),
      .regWriteW(regWriteW),
      .memToRegE(memToRegE),
      .branchTakenE(branchTakenE),
      .forwardAE(forwardAE),
      .forwardBE(forwardBE),
      .stallF(stallF),
      .stallD(stallD),
      .flushD(flushD),
      .flushE(flushE)
   );

endmodule

// ==== armCore_assert.sv ====
`timescale 1ns/1ps

module armCoreAssert (
   input logic clk,
   input logic reset,
   input logic stallD,
   input logic flushE,
   input logic memWrite,
   input logic branchTakenE
);

   // Load-use bubble goes into execute
   stallWithFlush: assert property (@(posedge clk) disable iff (reset) stallD |-> flushE)
      else $error("stallD without flushE");

   stallOneCycle: assert property (@(posedge clk) disable iff (reset) stallD |=> !stallD)
      else $error("stallD held longer than one cycle");

   noStoreInReset: assert property (@(posedge clk) reset |-> !memWrite)
      else $error("memWrite high during reset");

   // Branch itself is in memory then
   noStoreAfterBranch: assert property (@(posedge clk) disable iff (reset)
      branchTakenE |=> !memWrite)
      else $error("memWrite high right after a taken branch");

endmodule

// ==== tbArm.sv ====
`timescale 1ns/1ps

module tbArm
   import armPkg::*;
();

   localparam int PrologueLen = 30;
   localparam int RandomLen = 300;
   localparam int EpiStart = PrologueLen + RandomLen;
   localparam int ProgLen = EpiStart + 22;
   localparam int TimeoutCycles = ProgLen * 4 + 200;
   localparam logic [3:0] BaseReg = 4'd14;

   logic clk;
   logic reset;
   logic [WordWidth-1:0] instr, readData, pc, aluOut, writeData;
   logic memWrite;

   logic [31:0] imem [0:511];
   logic [31:0] dmem [0:255];
   logic [31:0] modelMem [0:255];
   logic [31:0] expAddr [$];
   logic [31:0] expData [$];
   int storeCount;

   armCore i_armCore (
      .clk(clk),
      .reset(reset),
      .instr(instr),
      .readData(readData),
      .pc(pc),
      .aluOut(aluOut),
      .writeData(writeData),
      .memWrite(memWrite)
   );

   bind armCore armCoreAssert i_armCoreAssert (
      .clk(clk),
      .reset(reset),
      .stallD(stallD),
      .flushE(flushE),
      .memWrite(memWrite),
      .branchTakenE(branchTakenE)
   );

   assign instr = imem[pc[10:2]];
   assign readData = dmem[aluOut[9:2]];

   always #10 clk = ~clk;

   function automatic logic [31:0] encodeDp(input logic [3:0] cond, input logic imm,
      input logic [3:0] cmd, input logic s, input logic [3:0] rn, input logic [3:0] rd,
      input logic [11:0] op2);
      return {cond, OpDataProc, imm, cmd, s, rn, rd, op2};
   endfunction

   function automatic logic [31:0] encodeMem(input logic [3:0] cond, input logic load,
      input logic [3:0] rn, input logic [3:0] rd, input logic [11:0] offset);
      return {cond, OpMemory, 1'b0, 4'b1100, load, rn, rd, offset};   // P=1 U=1
   endfunction

   function automatic logic [31:0] encodeBranch(input logic [3:0] cond, input int offset);
      return {cond, OpBranch, 2'b10, 24'(offset)};
   endfunction

   // ARM condition table on NZCV
   function automatic logic condHolds(input logic [3:0] cond, input logic [3:0] f);
      logic n, z, c, v;
      {n, z, c, v} = f;
      case (cond)
         4'h0: return z;
         4'h1: return !z;
         4'h2: return c;
         4'h3: return !c;
         4'h4: return n;
         4'h5: return !n;
         4'h6: return v;
         4'h7: return !v;
         4'h8: return c && !z;
         4'h9: return !c || z;
         4'hA: return n == v;
         4'hB: return n != v;
         4'hC: return !z && (n == v);
         4'hD: return z || (n != v);
         4'hE: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic logic [3:0] randomCond();
      if ($urandom % 2 == 0)
         return CondAlways;
      return 4'($urandom % 15);
   endfunction

   task automatic buildProgram();
      int off;
      int k;
      logic [3:0] cmds [4];
      logic imm;
      cmds = '{CmdAdd, CmdSub, CmdAnd, CmdOrr};
      for (int i = 0; i < 512; i++)
         imem[i] = {4'hF, 2'b11, 17'd0, 9'(i)};   // Never-executed filler
      for (int i = 0; i < 256; i++)
      begin
         dmem[i] = 32'(i) * 32'h9E3779B1 ^ 32'h13572468;
         modelMem[i] = dmem[i];
      end
      for (int r = 0; r < 15; r++)
      begin
         imem[2*r] = encodeDp(CondAlways, 1'b1, CmdAnd, 1'b0, 4'(r), 4'(r), 12'h000);
         imem[2*r+1] = encodeDp(CondAlways, 1'b1, CmdOrr, 1'b0, 4'(r), 4'(r),
                                (r == 14) ? 12'h080 : {4'h0, 8'($urandom)});
      end
      for (int i = PrologueLen; i < EpiStart; i++)
      begin
         k = $urandom % 20;
         if (k < 12)
         begin
            imm = 1'($urandom);
            imem[i] = encodeDp(randomCond(), imm, cmds[$urandom % 4], 1'($urandom),
                               4'($urandom % 15), 4'($urandom % 14),
                               imm ? {4'h0, 8'($urandom)} : {8'h0, 4'($urandom % 15)});
         end
         else if (k < 18)
            imem[i] = encodeMem(randomCond(), k < 15, BaseReg, 4'($urandom % 14),
                                12'(($urandom % 224) * 4));
         else
         begin
            off = $urandom % 3;
            if (i + 2 + off > EpiStart)
               off = EpiStart - i - 2;
            imem[i] = encodeBranch(randomCond(), off);
         end
      end
      for (int r = 0; r < 15; r++)
         imem[EpiStart+r] = encodeMem(CondAlways, 1'b0, BaseReg, 4'(r), 12'(4*r));
      // Pack NZCV into R0
      imem[EpiStart+15] = encodeDp(CondAlways, 1'b1, CmdAnd, 1'b0, 4'd0, 4'd0, 12'h000);
      imem[EpiStart+16] = encodeDp(4'h4, 1'b1, CmdOrr, 1'b0, 4'd0, 4'd0, 12'h008);
      imem[EpiStart+17] = encodeDp(4'h0, 1'b1, CmdOrr, 1'b0, 4'd0, 4'd0, 12'h004);
      imem[EpiStart+18] = encodeDp(4'h2, 1'b1, CmdOrr, 1'b0, 4'd0, 4'd0, 12'h002);
      imem[EpiStart+19] = encodeDp(4'h6, 1'b1, CmdOrr, 1'b0, 4'd0, 4'd0, 12'h001);
      imem[EpiStart+20] = encodeMem(CondAlways, 1'b0, BaseReg, 4'd0, 12'd60);
      imem[EpiStart+21] = encodeBranch(CondAlways, -2);   // Spin here
   endtask

   // Sequential instruction-set model that runs one instruction at a time
   task automatic runModel();
      logic [31:0] regs [0:15];
      logic [3:0] flags;
      logic [31:0] a, b, r, addr;
      logic [32:0] wide;
      instrT w;
      int idx;
      flags = 4'b0;
      idx = 0;
      for (int i = 0; i < 16; i++)
         regs[i] = '0;
      while (idx != ProgLen - 1)
      begin
         w = imem[idx];
         idx++;
         if (!condHolds(w.dp.cond, flags))
            continue;
         if (w.dp.op == OpDataProc)
         begin
            a = regs[w.dp.rn];
            b = w.dp.immFlag ? {24'h0, w.dp.operand2[7:0]} : regs[w.dp.operand2[3:0]];
            wide = {1'b0, a} + {1'b0, b};
            case (w.dp.cmd)
               CmdAdd: r = wide[31:0];
               CmdSub: r = a - b;
               CmdAnd: r = a & b;
               default: r = a | b;
            endcase
            regs[w.dp.rd] = r;
            if (w.dp.sBit)
            begin
               flags[3] = r[31];
               flags[2] = (r == 0);
               if (w.dp.cmd == CmdAdd)
                  flags[1:0] = {wide[32], (a[31] == b[31]) && (r[31] != a[31])};
               else if (w.dp.cmd == CmdSub)
                  flags[1:0] = {a >= b, (a[31] != b[31]) && (r[31] != a[31])};
            end
         end
         else if (w.dp.op == OpMemory)
         begin
            addr = regs[w.dp.rn] + {20'h0, w.dp.operand2};
            if (w.dp.sBit)
               regs[w.dp.rd] = modelMem[addr[9:2]];
            else
            begin
               modelMem[addr[9:2]] = regs[w.dp.rd];
               expAddr.push_back(addr);
               expData.push_back(regs[w.dp.rd]);
            end
         end
         else
            idx = idx + 1 + int'({{8{w.br.offset[23]}}, w.br.offset});   // PC+8 target
      end
   endtask

   task automatic compareValue(input string name, input logic [31:0] actual,
      input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("mismatch at %0t: %s actual %h expected %h", $time, name, actual, expected);
         $display("=== FAIL ===");
         $fatal(1, "value check failed");
      end
   endtask

   // Stores are checked mid-cycle where the memory stage is stable
   always @(negedge clk)
   begin
      if (!reset && memWrite)
      begin
         if (storeCount >= expAddr.size())
         begin
            $display("store at %0t was not expected by the model", $time);
            $display("=== FAIL ===");
            $fatal(1, "extra store");
         end
         compareValue("aluOut", aluOut, expAddr[storeCount]);
         compareValue("writeData", writeData, expData[storeCount]);
         dmem[aluOut[9:2]] = writeData;
         storeCount++;
      end
   end

   initial
   begin
      #(TimeoutCycles * 20);
      $display("timeout: the program did not finish its stores in time");
      $display("=== FAIL ===");
      $fatal(1, "watchdog expired");
   end

   initial
   begin
      void'($urandom(25));
      clk = 1'b0;
      reset = 1'b1;
      storeCount = 0;
      buildProgram();
      runModel();
      repeat (5) @(negedge clk);
      compareValue("pc", pc, 32'd0);   // Fetch starts at address 0
      reset = 1'b0;
      wait (storeCount == expAddr.size());
      repeat (2) @(negedge clk);
      $display("=== PASS ===");
      $finish;
   end

endmodule

// ==== files.f ====
armPkg.sv
armCondition.sv
armAlu.sv
armRegFile.sv
armHazard.sv
armControl.sv
armDatapath.sv
armCore.sv
armCore_assert.sv
tbArm.sv

// ==== run.sh ====
#!/bin/bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module tbArm -o simArm
output=$(./obj_dir/simArm 2>&1) || true
echo "$output"
if grep -q "=== PASS ===" <<< "$output"; then
   exit 0
else
   exit 1
fi
